/* src/mastermind_pkg.sv */
package mastermind_pkg;

    // pegs per code, fixed by the four guess digits on the display
    localparam int NUM_PEGS = 4;

    typedef logic [2:0]  peg_t;
    typedef logic [11:0] code_t;
    typedef logic [1:0]  slot_t;
    typedef logic [2:0]  score_t;
    typedef logic [6:0]  seg_t;

    // every entry state waits for a press, its _WAIT partner for the release
    typedef enum logic [4:0] {
        CODE_0,
        CODE_0_WAIT,
        CODE_1,
        CODE_1_WAIT,
        CODE_2,
        CODE_2_WAIT,
        CODE_3,
        CODE_3_WAIT,
        GUESS_0,
        GUESS_0_WAIT,
        GUESS_1,
        GUESS_1_WAIT,
        GUESS_2,
        GUESS_2_WAIT,
        GUESS_3,
        GUESS_3_WAIT,
        COMPARE_0,
        COMPARE_1,
        COMPARE_2,
        COMPARE_3
    } game_state_t;

endpackage

/* src/mastermind_control.sv */
`timescale 1ns/1ps

module mastermind_control (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  load_i,
    output logic                  code_load_o,
    output logic                  guess_load_o,
    output logic                  compare_o,
    output logic                  clear_score_o,
    output mastermind_pkg::slot_t slot_o,
    output mastermind_pkg::slot_t compare_index_o
);
    import mastermind_pkg::*;

    game_state_t state;
    game_state_t state_next;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state <= CODE_0;
        end else begin
            state <= state_next;
        end
    end

    // press moves to the wait state, release moves to the next peg
    always_comb begin
        state_next = state;
        case (state)
            CODE_0:       if (load_i)  state_next = CODE_0_WAIT;
            CODE_0_WAIT:  if (!load_i) state_next = CODE_1;
            CODE_1:       if (load_i)  state_next = CODE_1_WAIT;
            CODE_1_WAIT:  if (!load_i) state_next = CODE_2;
            CODE_2:       if (load_i)  state_next = CODE_2_WAIT;
            CODE_2_WAIT:  if (!load_i) state_next = CODE_3;
            CODE_3:       if (load_i)  state_next = CODE_3_WAIT;
            CODE_3_WAIT:  if (!load_i) state_next = GUESS_0;
            GUESS_0:      if (load_i)  state_next = GUESS_0_WAIT;
            GUESS_0_WAIT: if (!load_i) state_next = GUESS_1;
            GUESS_1:      if (load_i)  state_next = GUESS_1_WAIT;
            GUESS_1_WAIT: if (!load_i) state_next = GUESS_2;
            GUESS_2:      if (load_i)  state_next = GUESS_2_WAIT;
            GUESS_2_WAIT: if (!load_i) state_next = GUESS_3;
            GUESS_3:      if (load_i)  state_next = GUESS_3_WAIT;
            GUESS_3_WAIT: if (!load_i) state_next = COMPARE_0;
            // scoring runs one slot per cycle
            COMPARE_0:    state_next = COMPARE_1;
            COMPARE_1:    state_next = COMPARE_2;
            COMPARE_2:    state_next = COMPARE_3;
            COMPARE_3:    state_next = GUESS_0;
            default:      state_next = CODE_0;
        endcase
    end

    always_comb begin
        code_load_o     = 1'b0;
        guess_load_o    = 1'b0;
        compare_o       = 1'b0;
        clear_score_o   = 1'b0;
        slot_o          = 2'd0;
        compare_index_o = 2'd0;
        case (state)
            CODE_0: begin
                code_load_o = 1'b1;
                slot_o      = 2'd0;
            end
            CODE_1: begin
                code_load_o = 1'b1;
                slot_o      = 2'd1;
            end
            CODE_2: begin
                code_load_o = 1'b1;
                slot_o      = 2'd2;
            end
            CODE_3: begin
                code_load_o = 1'b1;
                slot_o      = 2'd3;
            end
            GUESS_0: begin
                guess_load_o = 1'b1;
                slot_o       = 2'd0;
            end
            GUESS_1: begin
                guess_load_o = 1'b1;
                slot_o       = 2'd1;
            end
            GUESS_2: begin
                guess_load_o = 1'b1;
                slot_o       = 2'd2;
            end
            GUESS_3: begin
                // old score stays up until the last guess peg
                guess_load_o  = 1'b1;
                clear_score_o = 1'b1;
                slot_o        = 2'd3;
            end
            COMPARE_0: begin
                compare_o       = 1'b1;
                compare_index_o = 2'd0;
            end
            COMPARE_1: begin
                compare_o       = 1'b1;
                compare_index_o = 2'd1;
            end
            COMPARE_2: begin
                compare_o       = 1'b1;
                compare_index_o = 2'd2;
            end
            COMPARE_3: begin
                compare_o       = 1'b1;
                compare_index_o = 2'd3;
            end
            default: begin
                code_load_o = 1'b0;
            end
        endcase
    end

endmodule

/* src/peg_registers.sv */
`timescale 1ns/1ps

module peg_registers (
    input  logic                  clock,
    input  logic                  resetn,
    input  logic                  code_load_i,
    input  logic                  guess_load_i,
    input  mastermind_pkg::slot_t slot_i,
    input  mastermind_pkg::peg_t  data_i,
    output mastermind_pkg::code_t code_o,
    output mastermind_pkg::code_t guess_o
);
    import mastermind_pkg::*;

    localparam int PEG_W = $bits(peg_t);

    // secret code, kept across rounds
    always_ff @(posedge clock) begin
        if (!resetn) begin
            code_o <= '0;
        end else if (code_load_i) begin
            code_o[slot_i*PEG_W +: PEG_W] <= data_i;
        end
    end

    // current guess, overwritten slot by slot each round
    always_ff @(posedge clock) begin
        if (!resetn) begin
            guess_o <= '0;
        end else if (guess_load_i) begin
            guess_o[slot_i*PEG_W +: PEG_W] <= data_i;
        end
    end

endmodule

/* src/peg_scorer.sv */
`timescale 1ns/1ps

module peg_scorer (
    input  logic                   clock,
    input  logic                   resetn,
    input  logic                   compare_i,
    input  logic                   clear_i,
    input  mastermind_pkg::slot_t  compare_index_i,
    input  mastermind_pkg::code_t  code_i,
    input  mastermind_pkg::code_t  guess_i,
    output mastermind_pkg::score_t red_o,
    output mastermind_pkg::score_t white_o
);
    import mastermind_pkg::*;

    localparam int PEG_W = $bits(peg_t);

    peg_t                code_peg;
    logic [NUM_PEGS-1:0] exact;
    logic [NUM_PEGS-1:0] used_q;
    logic [NUM_PEGS-1:0] pick;
    logic                found;
    logic                hit_red;

    assign code_peg = code_i[compare_index_i*PEG_W +: PEG_W];

    // slots already scored red never take part in white matching
    always_comb begin
        for (int k = 0; k < NUM_PEGS; k++) begin
            exact[k] = (code_i[k*PEG_W +: PEG_W] == guess_i[k*PEG_W +: PEG_W]);
        end
    end

    assign hit_red = exact[compare_index_i];

    // lowest free guess slot of the same colour
    always_comb begin
        pick  = '0;
        found = 1'b0;
        for (int k = 0; k < NUM_PEGS; k++) begin
            if (!found && !exact[k] && !used_q[k] &&
                guess_i[k*PEG_W +: PEG_W] == code_peg) begin
                pick[k] = 1'b1;
                found   = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!resetn || clear_i) begin
            used_q  <= '0;
            red_o   <= '0;
            white_o <= '0;
        end else if (compare_i) begin
            if (hit_red) begin
                red_o <= red_o + 3'd1;
            end else if (found) begin
                used_q  <= used_q | pick;
                white_o <= white_o + 3'd1;
            end
        end
    end

endmodule

/* src/seven_seg_decoder.sv */
`timescale 1ns/1ps

module seven_seg_decoder (
    input  mastermind_pkg::peg_t digit_i,
    output mastermind_pkg::seg_t segments_o
);

    // segments are active low, bit 6 is segment g
    always_comb begin
        case (digit_i)
            3'd0:    segments_o = 7'b100_0000;
            3'd1:    segments_o = 7'b111_1001;
            3'd2:    segments_o = 7'b010_0100;
            3'd3:    segments_o = 7'b011_0000;
            3'd4:    segments_o = 7'b001_1001;
            3'd5:    segments_o = 7'b001_0010;
            3'd6:    segments_o = 7'b000_0010;
            3'd7:    segments_o = 7'b111_1000;
            default: segments_o = 7'b111_1111;
        endcase
    end

endmodule

/* src/mastermind.sv */
`timescale 1ns/1ps

module mastermind (
    input  logic                 clock,
    input  logic                 resetn,
    input  logic                 load_i,
    input  mastermind_pkg::peg_t data_i,
    output mastermind_pkg::seg_t hex0_o,
    output mastermind_pkg::seg_t hex1_o,
    output mastermind_pkg::seg_t hex2_o,
    output mastermind_pkg::seg_t hex3_o,
    output mastermind_pkg::seg_t hex4_o,
    output mastermind_pkg::seg_t hex5_o
);
    import mastermind_pkg::*;

    logic   code_load;
    logic   guess_load;
    logic   compare;
    logic   clear_score;
    slot_t  slot;
    slot_t  compare_index;
    code_t  code;
    code_t  guess;
    score_t red;
    score_t white;

    mastermind_control control_inst (
        .clock           (clock),
        .resetn          (resetn),
        .load_i          (load_i),
        .code_load_o     (code_load),
        .guess_load_o    (guess_load),
        .compare_o       (compare),
        .clear_score_o   (clear_score),
        .slot_o          (slot),
        .compare_index_o (compare_index)
    );

    peg_registers registers_inst (
        .clock        (clock),
        .resetn       (resetn),
        .code_load_i  (code_load),
        .guess_load_i (guess_load),
        .slot_i       (slot),
        .data_i       (data_i),
        .code_o       (code),
        .guess_o      (guess)
    );

    peg_scorer scorer_inst (
        .clock           (clock),
        .resetn          (resetn),
        .compare_i       (compare),
        .clear_i         (clear_score),
        .compare_index_i (compare_index),
        .code_i          (code),
        .guess_i         (guess),
        .red_o           (red),
        .white_o         (white)
    );

    // guess slots on hex0 to hex3, score on hex4 and hex5
    seven_seg_decoder hex0_inst (.digit_i(guess[2:0]),  .segments_o(hex0_o));
    seven_seg_decoder hex1_inst (.digit_i(guess[5:3]),  .segments_o(hex1_o));
    seven_seg_decoder hex2_inst (.digit_i(guess[8:6]),  .segments_o(hex2_o));
    seven_seg_decoder hex3_inst (.digit_i(guess[11:9]), .segments_o(hex3_o));
    seven_seg_decoder hex4_inst (.digit_i(red),         .segments_o(hex4_o));
    seven_seg_decoder hex5_inst (.digit_i(white),       .segments_o(hex5_o));

endmodule

/* bench/mastermind_asserts.sv */
`timescale 1ns/1ps

module mastermind_asserts (
    input logic                        clock,
    input logic                        resetn,
    input logic                        code_load_i,
    input logic                        guess_load_i,
    input logic                        compare_i,
    input mastermind_pkg::game_state_t state_i
);
    import mastermind_pkg::*;

    // only one register may take data_i
    load_exclusive: assert property (@(posedge clock) disable iff (!resetn)
        !(code_load_i && guess_load_i))
        else $error("code and guess load high together");

    // scoring takes exactly one cycle per slot
    compare_length: assert property (@(posedge clock) disable iff (!resetn)
        $rose(compare_i) |-> compare_i [*4] ##1 !compare_i)
        else $error("compare not high for four cycles");

    reset_state: assert property (@(posedge clock)
        !resetn |=> state_i == CODE_0)
        else $error("state not CODE_0 after reset");

endmodule

bind mastermind_control mastermind_asserts asserts_inst (
    .clock        (clock),
    .resetn       (resetn),
    .code_load_i  (code_load_o),
    .guess_load_i (guess_load_o),
    .compare_i    (compare_o),
    .state_i      (state)
);

/* bench/mastermind_tb.sv */
`timescale 1ns/1ps

module mastermind_tb;
    import mastermind_pkg::*;

    localparam int CLK_PERIOD = 20;
    // pegs entered over all tests, code and guess pegs together
    localparam int TOTAL_PEGS = 156;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_PEGS + 200;

    logic  clock;
    logic  resetn;
    logic  load;
    peg_t  data;
    seg_t  hex [6];
    code_t secret;

    mastermind mastermind_inst (
        .clock  (clock),
        .resetn (resetn),
        .load_i (load),
        .data_i (data),
        .hex0_o (hex[0]),
        .hex1_o (hex[1]),
        .hex2_o (hex[2]),
        .hex3_o (hex[3]),
        .hex4_o (hex[4]),
        .hex5_o (hex[5])
    );

    initial clock = 1'b0;
    always #(CLK_PERIOD / 2) clock = ~clock;

    // active-low patterns, bit 6 is segment g
    function automatic seg_t seg_of(input peg_t digit);
        case (digit)
            3'd0:    return 7'b100_0000;
            3'd1:    return 7'b111_1001;
            3'd2:    return 7'b010_0100;
            3'd3:    return 7'b011_0000;
            3'd4:    return 7'b001_1001;
            3'd5:    return 7'b001_0010;
            3'd6:    return 7'b000_0010;
            default: return 7'b111_1000;
        endcase
    endfunction

    function automatic code_t pack_pegs(input peg_t p0, input peg_t p1,
                                        input peg_t p2, input peg_t p3);
        return {p3, p2, p1, p0};
    endfunction

    function automatic peg_t peg_at(input code_t c, input int k);
        return c[k*3 +: 3];
    endfunction

    function automatic int model_red(input code_t c, input code_t g);
        int n;
        n = 0;
        for (int k = 0; k < NUM_PEGS; k++) begin
            if (peg_at(c, k) == peg_at(g, k)) n++;
        end
        return n;
    endfunction

    // per colour minimum of both counts, reds taken out
    function automatic int model_white(input code_t c, input code_t g);
        int code_cnt [8];
        int guess_cnt [8];
        int n;
        n = 0;
        for (int v = 0; v < 8; v++) begin
            code_cnt[v]  = 0;
            guess_cnt[v] = 0;
        end
        for (int k = 0; k < NUM_PEGS; k++) begin
            code_cnt[peg_at(c, k)]++;
            guess_cnt[peg_at(g, k)]++;
        end
        for (int v = 0; v < 8; v++) begin
            n += (code_cnt[v] < guess_cnt[v]) ? code_cnt[v] : guess_cnt[v];
        end
        return n - model_red(c, g);
    endfunction

    task automatic check_value(input string test, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("Fail %s: expected %0h, actual %0h", test, expected, actual);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // five cycles low with the button released
    task automatic apply_reset();
        resetn = 1'b0;
        load   = 1'b0;
        repeat (5) @(posedge clock);
        #2;
        resetn = 1'b1;
    endtask

    // two cycles held, two released
    task automatic enter_peg(input peg_t p);
        data = p;
        load = 1'b1;
        repeat (2) @(posedge clock);
        #2;
        load = 1'b0;
        repeat (2) @(posedge clock);
        #2;
    endtask

    // only reset brings the controller back to code entry
    task automatic enter_code(input code_t c);
        apply_reset();
        for (int k = 0; k < NUM_PEGS; k++) enter_peg(peg_at(c, k));
        secret = c;
    endtask

    task automatic enter_guess(input code_t g);
        for (int k = 0; k < NUM_PEGS; k++) enter_peg(peg_at(g, k));
    endtask

    // enter_peg already spent two of the five cycles after release
    task automatic check_score(input string test, input code_t g);
        repeat (3) @(posedge clock);
        #2;
        check_value({test, " red"}, seg_of(model_red(secret, g)), hex[4]);
        check_value({test, " white"}, seg_of(model_white(secret, g)), hex[5]);
    endtask

    task automatic play_round(input string test, input code_t g);
        enter_guess(g);
        check_score(test, g);
    endtask

    task automatic reset_test();
        for (int k = 0; k < 6; k++) begin
            check_value($sformatf("reset hex%0d", k), seg_of(3'd0), hex[k]);
        end
    endtask

    task automatic guess_echo_test();
        code_t g;
        g = pack_pegs(3'd3, 3'd6, 3'd1, 3'd7);
        enter_code(pack_pegs(3'd2, 3'd6, 3'd5, 3'd7));
        for (int k = 0; k < NUM_PEGS; k++) begin
            enter_peg(peg_at(g, k));
            check_value($sformatf("echo hex%0d", k), seg_of(peg_at(g, k)), hex[k]);
        end
        check_score("echo score", g);
    endtask

    task automatic exact_guess_test();
        enter_code(pack_pegs(3'd6, 3'd2, 3'd7, 3'd0));
        play_round("exact match", pack_pegs(3'd6, 3'd2, 3'd7, 3'd0));
        play_round("no shared colour", pack_pegs(3'd1, 3'd3, 3'd4, 3'd5));
    endtask

    task automatic permutation_test();
        enter_code(pack_pegs(3'd1, 3'd2, 3'd3, 3'd4));
        play_round("permutation", pack_pegs(3'd4, 3'd3, 3'd2, 3'd1));
        enter_code(pack_pegs(3'd1, 3'd1, 3'd2, 3'd2));
        play_round("duplicates", pack_pegs(3'd1, 3'd2, 3'd1, 3'd3));
        enter_code(pack_pegs(3'd5, 3'd5, 3'd5, 3'd5));
        play_round("single colour", pack_pegs(3'd5, 3'd0, 3'd0, 3'd5));
    endtask

    // four guesses per code, the code is entered only once
    task automatic random_test();
        code_t c;
        code_t g;
        for (int n = 0; n < 5; n++) begin
            c = pack_pegs($urandom_range(7, 0), $urandom_range(7, 0),
                          $urandom_range(7, 0), $urandom_range(7, 0));
            enter_code(c);
            for (int r = 0; r < 4; r++) begin
                g = pack_pegs($urandom_range(7, 0), $urandom_range(7, 0),
                              $urandom_range(7, 0), $urandom_range(7, 0));
                play_round($sformatf("random code %0d guess %0d", n, r), g);
            end
        end
    endtask

    // score is sampled one cycle into each press
    task automatic press_checking_score(input peg_t p, input int exp_red,
                                        input int exp_white, input string test);
        data = p;
        load = 1'b1;
        @(posedge clock);
        #2;
        check_value({test, " red"}, seg_of(exp_red), hex[4]);
        check_value({test, " white"}, seg_of(exp_white), hex[5]);
        @(posedge clock);
        #2;
        load = 1'b0;
        repeat (2) @(posedge clock);
        #2;
    endtask

    // setup round leaves both counts nonzero
    task automatic clear_timing_test();
        code_t setup;
        code_t g;
        setup = pack_pegs(3'd1, 3'd2, 3'd4, 3'd3);
        g     = pack_pegs(3'd4, 3'd3, 3'd2, 3'd1);
        enter_code(pack_pegs(3'd1, 3'd2, 3'd3, 3'd4));
        play_round("clear setup", setup);
        for (int k = 0; k < NUM_PEGS - 1; k++) begin
            press_checking_score(peg_at(g, k), model_red(secret, setup),
                                 model_white(secret, setup),
                                 $sformatf("clear hold peg %0d", k));
        end
        press_checking_score(peg_at(g, 3), 0, 0, "clear last peg");
        check_score("clear rescore", g);
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run hung and no test finished in time");
        $display("Simulation failed");
        $fatal(1, "watchdog");
    end

    initial begin
        void'($urandom(32'h816a_39e2));
        data   = '0;
        secret = '0;
        apply_reset();
        reset_test();
        guess_echo_test();
        exact_guess_test();
        permutation_test();
        random_test();
        clear_timing_test();
        $display("Simulation passed");
        $finish;
    end

endmodule

/* list.f */
src/mastermind_pkg.sv
src/mastermind_control.sv
src/peg_registers.sv
src/peg_scorer.sv
src/seven_seg_decoder.sv
src/mastermind.sv
bench/mastermind_asserts.sv
bench/mastermind_tb.sv
